// ==== source/kd_tree_pkg.sv ====
// Component, patch and split record types with their widths
`default_nettype none

package kd_tree_pkg;

  // Width of one unsigned patch component
  localparam int COMP_WIDTH = 11;

  // Components per query patch
  localparam int NUM_DIMS = 5;

  // Dimension selector width, enough for NUM_DIMS plus out-of-range codes
  localparam int DIM_WIDTH = 3;

  // One patch component
  typedef logic [COMP_WIDTH-1:0] component_t;

  // Whole query patch, component 0 in the low bits
  typedef component_t [NUM_DIMS-1:0] patch_t;

  // Split record held by each internal node
  typedef struct packed {
    logic [DIM_WIDTH-1:0] dim;
    component_t           threshold;
  } split_t;

endpackage

`default_nettype wire

// ==== source/kd_split_loader.sv ====
// Split write-address counter with wrap and one-hot node write-enable decoder
`timescale 1ns/1ps
`default_nettype none

module kd_split_loader #(
  parameter int TREE_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          load_enable,
  input  logic                          split_valid,
  output logic [(2**TREE_DEPTH)-2:0]    node_we
);

  // Internal nodes of a complete tree with TREE_DEPTH levels
  localparam int NUM_NODES = (2**TREE_DEPTH) - 1;

  // Node numbers stay below 2^TREE_DEPTH, so TREE_DEPTH bits suffice
  localparam logic [TREE_DEPTH-1:0] LAST_NODE = TREE_DEPTH'(NUM_NODES - 1);

  logic                  wr;
  logic [TREE_DEPTH-1:0] wr_addr;

  // Write only in load phase with the strobe high
  assign wr = load_enable && split_valid;

  // Breadth-first address, steps once per write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (wr) begin
      // Back to the root after the last node
      if (wr_addr == LAST_NODE) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // Address decoder, gated so no bit rises without a write
  always_comb begin
    for (int n = 0; n < NUM_NODES; n++) begin
      node_we[n] = wr && (wr_addr == TREE_DEPTH'(n));
    end
  end

endmodule

`default_nettype wire

// ==== source/kd_internal_node.sv ====
// Single KD-tree node with split storage and left/right valid routing
`timescale 1ns/1ps
`default_nettype none

module kd_internal_node
  import kd_tree_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   wen,
  input  split_t split_in,
  input  logic   valid,
  input  patch_t patch,
  output logic   valid_left,
  output logic   valid_right
);

  split_t     split_q;
  component_t sel_comp;
  logic       go_right;

  // Stored split, zero after reset so an empty node sends everything right
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      split_q <= '0;
    end else if (wen) begin
      split_q <= split_in;
    end
  end

  // Component picked by the stored dimension
  // Codes at or above NUM_DIMS fall back to component 0
  always_comb begin
    sel_comp = patch[0];
    for (int d = 1; d < NUM_DIMS; d++) begin
      if (split_q.dim == DIM_WIDTH'(d)) begin
        sel_comp = patch[d];
      end
    end
  end

  // Equal to threshold counts as right
  assign go_right = (sel_comp >= split_q.threshold);

  // Exactly one child sees the incoming valid
  assign valid_right = valid && go_right;
  assign valid_left  = valid && !go_right;

endmodule

`default_nettype wire

// ==== source/kd_tree_level.sv ====
// One tree depth of nodes with its patch and child-valid pipeline register
`timescale 1ns/1ps
`default_nettype none

module kd_tree_level
  import kd_tree_pkg::*;
#(
  parameter int LEVEL      = 0,
  parameter int TREE_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [(2**LEVEL)-1:0]     node_we,
  input  split_t                    split_in,
  input  patch_t                    patch_in,
  input  logic [(2**LEVEL)-1:0]     valid_in,
  output patch_t                    patch_out,
  output logic [(2**(LEVEL+1))-1:0] valid_out
);

  // Nodes at this depth
  localparam int NODES = 2**LEVEL;

  // Child valids before the register, two per node
  logic [(2*NODES)-1:0] child_valid;

  // Catch a level placed below the leaves
  if (LEVEL >= TREE_DEPTH) begin : g_bad_level
    $error("kd_tree_level: LEVEL must be below TREE_DEPTH");
  end

  // Node j feeds children 2j (left) and 2j+1 (right)
  for (genvar j = 0; j < NODES; j++) begin : g_node
    kd_internal_node u_node (
      .clk         (clk),
      .rst_n       (rst_n),
      .wen         (node_we[j]),
      .split_in    (split_in),
      .valid       (valid_in[j]),
      .patch       (patch_in),
      .valid_left  (child_valid[2*j]),
      .valid_right (child_valid[(2*j)+1])
    );
  end

  // Valid stage, cleared so nothing leaves the pipe after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_out <= '0;
    end else begin
      valid_out <= child_valid;
    end
  end

  // Patch travels alongside its valids
  always_ff @(posedge clk) begin
    patch_out <= patch_in;
  end

endmodule

`default_nettype wire

// ==== source/kd_leaf_encoder.sv ====
// Leaf one-hot to index encoder with leaf-valid output
`timescale 1ns/1ps
`default_nettype none

module kd_leaf_encoder #(
  parameter int TREE_DEPTH = 4
) (
  input  logic [(2**TREE_DEPTH)-1:0] leaf_valids,
  output logic                       leaf_valid,
  output logic [TREE_DEPTH-1:0]      leaf_index
);

  localparam int LEAVES = 2**TREE_DEPTH;

  // Any leaf reached means a finished search
  assign leaf_valid = |leaf_valids;

  // Highest set bit wins; at most one is ever set
  // Zero when the vector is empty
  always_comb begin
    leaf_index = '0;
    for (int i = 0; i < LEAVES; i++) begin
      if (leaf_valids[i]) begin
        leaf_index = TREE_DEPTH'(i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/kd_tree_search.sv ====
// KD-tree leaf search top level with loader, level pipeline and leaf encoder
`timescale 1ns/1ps
`default_nettype none

module kd_tree_search
  import kd_tree_pkg::*;
#(
  parameter int TREE_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load_enable,
  input  logic                  split_valid,
  input  split_t                split_data,
  input  logic                  query_valid,
  input  patch_t                query_patch,
  output logic                  leaf_valid,
  output logic [TREE_DEPTH-1:0] leaf_index
);

  // Per-node write enables, breadth-first order
  logic [(2**TREE_DEPTH)-2:0] node_we;

  kd_split_loader #(
    .TREE_DEPTH (TREE_DEPTH)
  ) u_loader (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_enable (load_enable),
    .split_valid (split_valid),
    .node_we     (node_we)
  );

  // Level i owns nodes 2^i-1 .. 2^(i+1)-2
  for (genvar i = 0; i < TREE_DEPTH; i++) begin : g_level
    patch_t                    patch_in_w;
    logic [(2**i)-1:0]         valid_in_w;
    patch_t                    patch_out_w;
    logic [(2**(i+1))-1:0]     valid_out_w;

    if (i == 0) begin : g_root
      // Root takes the query straight from the ports
      assign patch_in_w = query_patch;
      assign valid_in_w = query_valid;
    end else begin : g_inner
      assign patch_in_w = g_level[i-1].patch_out_w;
      assign valid_in_w = g_level[i-1].valid_out_w;
    end

    kd_tree_level #(
      .LEVEL      (i),
      .TREE_DEPTH (TREE_DEPTH)
    ) u_level (
      .clk       (clk),
      .rst_n     (rst_n),
      .node_we   (node_we[(2**(i+1))-2:(2**i)-1]),
      .split_in  (split_data),
      .patch_in  (patch_in_w),
      .valid_in  (valid_in_w),
      .patch_out (patch_out_w),
      .valid_out (valid_out_w)
    );
  end

  // Last stage valids are the leaves
  kd_leaf_encoder #(
    .TREE_DEPTH (TREE_DEPTH)
  ) u_encoder (
    .leaf_valids (g_level[TREE_DEPTH-1].valid_out_w),
    .leaf_valid  (leaf_valid),
    .leaf_index  (leaf_index)
  );

endmodule

`default_nettype wire

// ==== tests/kd_tree_search_asserts.sv ====
// Concurrent assertions on the KD-tree search ports and their bind to the top level
`timescale 1ns/1ps
`default_nettype none

module kd_tree_search_asserts #(
  parameter int TREE_DEPTH = 4
) (
  input wire logic                  clk,
  input wire logic                  rst_n,
  input wire logic                  query_valid,
  input wire logic                  leaf_valid,
  input wire logic [TREE_DEPTH-1:0] leaf_index
);

  // Cycles since reset went away, saturating
  int since_rst = 0;

  always @(posedge clk) begin
    if (!rst_n) begin
      since_rst <= 0;
    end else if (since_rst < 1000) begin
      since_rst <= since_rst + 1;
    end
  end

  // Pipe is empty during reset and right after it
  a_quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !leaf_valid)
    else $error("leaf_valid high during or just after reset");

  // One result per query, exactly TREE_DEPTH cycles later
  a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (since_rst >= TREE_DEPTH) |-> (leaf_valid == $past(query_valid, TREE_DEPTH)))
    else $error("leaf_valid does not follow query_valid by TREE_DEPTH cycles");

  a_index_known: assert property (@(posedge clk) disable iff (!rst_n)
    leaf_valid |-> !$isunknown(leaf_index))
    else $error("leaf_index has unknown bits while leaf_valid is high");

endmodule

bind kd_tree_search kd_tree_search_asserts #(
  .TREE_DEPTH (TREE_DEPTH)
) u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .query_valid (query_valid),
  .leaf_valid  (leaf_valid),
  .leaf_index  (leaf_index)
);

`default_nettype wire

// ==== tests/kd_tree_search_tb.sv ====
// KD-tree search testbench with clock, reset, LFSR, reference tree, stimulus, checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module kd_tree_search_tb
  import kd_tree_pkg::*;
;

  localparam int TREE_DEPTH  = 4;
  localparam int NUM_NODES   = (2**TREE_DEPTH) - 1;
  localparam int CLK_PERIOD  = 40;
  // Busy cycles over all tests with gated writes and the idle gaps of test 3
  localparam int NUM_WRITES  = 15 + 6 + 18;
  localparam int NUM_QUERIES = 20 + 8 + 200 + 20 + 20;
  localparam int NUM_GAPS    = 25;
  localparam int WATCHDOG_NS = (NUM_WRITES + NUM_QUERIES + NUM_GAPS + 50) * CLK_PERIOD;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  load_enable;
  logic                  split_valid;
  split_t                split_data;
  logic                  query_valid;
  patch_t                query_patch;
  logic                  leaf_valid;
  logic [TREE_DEPTH-1:0] leaf_index;

  // Mirror of the stored splits and of the loader pointer
  split_t      ref_splits [NUM_NODES];
  int          ref_ptr = 0;
  logic [31:0] lfsr = 32'hbc88_1ca8;
  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  // Expected leaf and arrival cycle per query in flight
  logic [TREE_DEPTH-1:0] exp_q [$];
  int                    cyc_q [$];
  logic [TREE_DEPTH-1:0] exp_leaf;
  int                    exp_cyc;

  kd_tree_search #(
    .TREE_DEPTH (TREE_DEPTH)
  ) u_kd_tree_search (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_enable (load_enable),
    .split_valid (split_valid),
    .split_data  (split_data),
    .query_valid (query_valid),
    .query_patch (query_patch),
    .leaf_valid  (leaf_valid),
    .leaf_index  (leaf_index)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Edge counter for latency checks
  always @(posedge clk) cyc <= cyc + 1;

  // Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic patch_t random_patch();
    patch_t p;
    for (int d = 0; d < NUM_DIMS; d++) begin
      p[d] = component_t'(take_bits(COMP_WIDTH));
    end
    return p;
  endfunction

  function automatic split_t random_split();
    split_t s;
    s.dim       = DIM_WIDTH'(take_bits(DIM_WIDTH));
    s.threshold = component_t'(take_bits(COMP_WIDTH));
    return s;
  endfunction

  // Dimension codes past the patch fall back to component 0
  function automatic int dim_index(input split_t s);
    return (int'(s.dim) < NUM_DIMS) ? int'(s.dim) : 0;
  endfunction

  // Node a patch reaches after depth steps when going right on >= and left otherwise
  function automatic int node_at(input patch_t p, input int depth);
    int     node;
    split_t s;
    node = 0;
    for (int lv = 0; lv < depth; lv++) begin
      s = ref_splits[node];
      node = (p[dim_index(s)] >= s.threshold) ? (2 * node) + 2 : (2 * node) + 1;
    end
    return node;
  endfunction

  // Leaf reached in the mirrored tree
  function automatic logic [TREE_DEPTH-1:0] ref_leaf(input patch_t p);
    return TREE_DEPTH'(node_at(p, TREE_DEPTH) - NUM_NODES);
  endfunction

  // Random patch that hits the threshold (or one below) at the node reached at depth
  function automatic patch_t edge_patch(input int depth, input bit below);
    patch_t p;
    split_t s;
    int     node;
    int     tries;
    tries = 0;
    // Retry while the changed component also moves an upper decision
    do begin
      p = random_patch();
      node = node_at(p, depth);
      s = ref_splits[node];
      if (below && s.threshold != '0) begin
        p[dim_index(s)] = s.threshold - component_t'(1);
      end else begin
        p[dim_index(s)] = s.threshold;
      end
      tries++;
    end while (node_at(p, depth) != node && tries < 64);
    return p;
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    query_valid <= 1'b0;
    load_enable <= 1'b0;
    split_valid <= 1'b0;
  endtask

  // Mirror updates only when both the phase level and strobe are high
  task automatic write_split(input logic le, input logic sv, input split_t s);
    @(posedge clk);
    query_valid <= 1'b0;
    load_enable <= le;
    split_valid <= sv;
    split_data  <= s;
    if (le && sv) begin
      ref_splits[ref_ptr] = s;
      ref_ptr = (ref_ptr == NUM_NODES - 1) ? 0 : ref_ptr + 1;
    end
  endtask

  // Query driven at edge c is sampled at c+1 and answered after edge c+TREE_DEPTH
  task automatic send_query(input patch_t p);
    @(posedge clk);
    load_enable <= 1'b0;
    split_valid <= 1'b0;
    query_valid <= 1'b1;
    query_patch <= p;
    exp_q.push_back(ref_leaf(p));
    cyc_q.push_back(cyc + 1 + TREE_DEPTH);
  endtask

  // Idle until every query in flight is answered
  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 4 * TREE_DEPTH) begin
      idle_cycle();
      n++;
    end
  endtask

  // Compare each finished search with the oldest expected leaf at the falling edge
  always @(negedge clk) begin
    if (rst_n && leaf_valid) begin
      if (exp_q.size() == 0) begin
        $display("Error at %0t: leaf_valid high with no query outstanding", $time);
        errors++;
      end else begin
        exp_leaf = exp_q.pop_front();
        exp_cyc  = cyc_q.pop_front();
        checks++;
        if (leaf_index !== exp_leaf) begin
          $display("Fail at %0t: leaf_index expected %0d, got %0d", $time, exp_leaf, leaf_index);
          errors++;
        end
        if (cyc != exp_cyc) begin
          $display("Fail at %0t: result in cycle %0d, expected cycle %0d", $time, cyc, exp_cyc);
          errors++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    split_t s;
    for (int n = 0; n < NUM_NODES; n++) begin
      ref_splits[n] = '0;
    end
    rst_n       = 1'b0;
    load_enable = 1'b0;
    split_valid = 1'b0;
    split_data  = '0;
    query_valid = 1'b0;
    query_patch = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Empty tree gives a quiet output and sends every query to the last leaf
    repeat (2) idle_cycle();
    for (int i = 0; i < 20; i++) send_query(random_patch());
    drain();

    // Full load with out-of-range dimension codes at node 0 and node 2
    for (int n = 0; n < NUM_NODES; n++) begin
      s = random_split();
      if (n == 0) s.dim = DIM_WIDTH'(7);
      if (n == 2) s.dim = DIM_WIDTH'(NUM_DIMS);
      write_split(1'b1, 1'b1, s);
    end
    idle_cycle();
    for (int depth = 0; depth < TREE_DEPTH; depth++) begin
      send_query(edge_patch(depth, 1'b0));
      send_query(edge_patch(depth, 1'b1));
    end

    // Back-to-back stream with a gap after every eighth query
    for (int i = 0; i < 200; i++) begin
      send_query(random_patch());
      if (i % 8 == 7) idle_cycle();
    end
    drain();

    // Strobe without the load phase and load phase without strobe
    for (int i = 0; i < 3; i++) begin
      write_split(1'b0, 1'b1, random_split());
      write_split(1'b1, 1'b0, random_split());
    end
    for (int i = 0; i < 20; i++) send_query(random_patch());
    drain();

    // Three writes past the end wrap onto nodes 0..2
    for (int n = 0; n < NUM_NODES + 3; n++) write_split(1'b1, 1'b1, random_split());
    idle_cycle();
    for (int i = 0; i < 20; i++) send_query(random_patch());
    drain();

    if (exp_q.size() != 0) begin
      $display("Error: %0d queries never produced a result", exp_q.size());
      errors++;
    end
    $display("Results checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== kd_tree_search.f ====
source/kd_tree_pkg.sv
source/kd_split_loader.sv
source/kd_internal_node.sv
source/kd_tree_level.sv
source/kd_leaf_encoder.sv
source/kd_tree_search.sv
tests/kd_tree_search_asserts.sv
tests/kd_tree_search_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the KD-tree search testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f kd_tree_search.f \
  --top-module kd_tree_search_tb \
  -o kd_tree_search_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/kd_tree_search_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
